//--- addr_decoder.sv
// SDMAC address decoder, maps longword address and bus strobes to active-low selects
module addr_decoder (
  input  logic [6:2] addr,       // CPU longword address
  input  logic       cs_n,       // SDMAC chip select
  input  logic       as_n,       // CPU address strobe
  output logic       dawr_n,     // Width register select
  output logic       wtc_n,      // Count register select
  output logic       cntr_n,     // Control register select
  output logic       st_dma_n,   // Start DMA select
  output logic       flush_n,    // Flush select
  output logic       clr_int_n,  // Clear interrupts select
  output logic       istr_n,     // Status register select
  output logic       sp_dma_n,   // Stop DMA select
  output logic       css_n,      // SCSI controller port
  output logic       csx0_n,     // Ports 1A and 1B
  output logic       csx1_n      // Port 2
);
  import sdmac_addr_pkg::*;

  logic [6:0] byte_off;  // Byte offset of the addressed longword
  logic [6:0] grp_base;  // Base of the 16-byte group
  logic       access;    // Chip select and strobe both low
  reg_sel_e   sel;       // Target before access qualification

  assign byte_off = {addr, 2'b00};
  assign grp_base = {byte_off[6:4], 4'h0};
  assign access   = !cs_n && !as_n;

  // Register offsets match exactly, ports by group
  always_comb begin
    case (byte_off)
      off_dawr:    sel = dawr;
      off_wtc:     sel = wtc;
      off_cntr:    sel = cntr;
      off_st_dma:  sel = st_dma;
      off_flush:   sel = flush;
      off_clr_int: sel = clr_int;
      off_istr:    sel = istr;
      off_sp_dma:  sel = sp_dma;
      default: begin
        case (grp_base)
          off_port0:              sel = port0;
          off_port1a, off_port1b: sel = port1;  // Both halves on one pin
          off_port2:              sel = port2;
          default:                sel = none;   // Gaps in the register area
        endcase
      end
    endcase
  end

  // Every select needs a live access
  assign dawr_n    = !(access && (sel == dawr));
  assign wtc_n     = !(access && (sel == wtc));
  assign cntr_n    = !(access && (sel == cntr));
  assign st_dma_n  = !(access && (sel == st_dma));
  assign flush_n   = !(access && (sel == flush));
  assign clr_int_n = !(access && (sel == clr_int));
  assign istr_n    = !(access && (sel == istr));
  assign sp_dma_n  = !(access && (sel == sp_dma));

  assign css_n     = !(access && (sel == port0));
  assign csx0_n    = !(access && (sel == port1));
  assign csx1_n    = !(access && (sel == port2));

endmodule

//--- dma_sequencer.sv
// SDMAC DMA sequencer, counts words on requests and flags terminal count and flush
module dma_sequencer #(
  parameter int wtc_width = 24                 // Word count width
) (
  input  logic                 cpuclk,         // CPU clock
  input  logic                 rst_n,          // Sync reset
  input  logic                 start_p,        // Start DMA pulse
  input  logic                 stop_p,         // Stop DMA pulse
  input  logic                 flush_p,        // Flush pulse
  input  logic                 dreq,           // Transfer request
  input  logic [wtc_width-1:0] wtc_load,       // Count loaded on start
  output logic [wtc_width-1:0] wtc_rem,        // Words still to move
  output logic                 tc_p,           // Terminal count pulse
  output logic                 flush_done_p,   // Flush finished pulse
  output logic                 dack_n,         // Request acknowledge
  output logic                 dma_active      // Transfer in progress
);
  import sdmac_ctrl_pkg::*;

  dma_state_e           state;      // Idle or active
  logic [wtc_width-1:0] count;      // Remaining words
  logic                 last_word;  // This request ends the transfer

  assign last_word  = (count == wtc_width'(1));
  assign wtc_rem    = count;
  assign dma_active = (state != dma_idle);

  // Stop and flush win over start, start over counting
  always_ff @(posedge cpuclk) begin
    if (!rst_n) begin
      state        <= dma_idle;
      count        <= '0;
      tc_p         <= 1'b0;
      flush_done_p <= 1'b0;
      dack_n       <= 1'b1;
    end else begin
      tc_p         <= 1'b0;
      dack_n       <= 1'b1;
      flush_done_p <= flush_p;                    // No FIFO, flush ends at once
      if (stop_p || flush_p) begin
        state <= dma_idle;                        // Abort, count kept for readback
      end else if (start_p) begin
        count <= wtc_load;
        if (wtc_load == '0) begin
          state <= dma_idle;                      // Nothing to move
          tc_p  <= 1'b1;
        end else begin
          state <= sdmac_ctrl_pkg::dma_active;    // Port of same name hides the value
        end
      end else if ((state != dma_idle) && dreq) begin
        count  <= count - 1'b1;
        dack_n <= 1'b0;                           // Ack in the cycle after the request
        if (last_word) begin
          tc_p  <= 1'b1;
          state <= dma_idle;
        end
      end
    end
  end

endmodule

//--- int_status.sv
// SDMAC interrupt status, latches DMA events, builds status word and interrupt output
module int_status (
  input  logic                                  cpuclk,        // CPU clock
  input  logic                                  rst_n,         // Sync reset
  input  logic                                  tc_p,          // Terminal count pulse
  input  logic                                  flush_done_p,  // Flush finished pulse
  input  logic                                  clr_int_p,     // Clear latches
  input  logic                                  scsi_int,      // SCSI controller level
  input  logic                                  ext_int,       // External level
  input  logic                                  inten,         // Output enable
  output logic [sdmac_ctrl_pkg::istr_width-1:0] istr_word,     // Status word
  output logic                                  int2_n         // Interrupt to host
);
  import sdmac_ctrl_pkg::*;

  logic tc_q;   // Terminal count seen
  logic ff_q;   // Flush done seen
  logic int_p;  // Any source pending

  // A new event beats a clear in the same cycle
  always_ff @(posedge cpuclk) begin
    if (!rst_n) begin
      tc_q <= 1'b0;
      ff_q <= 1'b0;
    end else begin
      if (tc_p) begin
        tc_q <= 1'b1;
      end else if (clr_int_p) begin
        tc_q <= 1'b0;
      end
      if (flush_done_p) begin
        ff_q <= 1'b1;
      end else if (clr_int_p) begin
        ff_q <= 1'b0;
      end
    end
  end

  assign int_p = tc_q || ff_q || ext_int || scsi_int;  // Levels pass straight through

  always_comb begin
    istr_word              = '0;
    istr_word[istr_ff_flg] = ff_q;
    istr_word[istr_tc]     = tc_q;
    istr_word[istr_e_int]  = ext_int;
    istr_word[istr_scsi]   = scsi_int;
    istr_word[istr_int_p]  = int_p;
  end

  assign int2_n = !(int_p && inten);  // Low only when enabled

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SDMAC testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_sdmac -f sdmac.f -o sim_sdmac
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_sdmac
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulation failed with status $sim_status"
  exit 1
fi

echo "Simulation finished with status 0"
exit 0

//--- sdmac.f
sdmac_addr_pkg.sv
sdmac_ctrl_pkg.sv
addr_decoder.sv
sdmac_regs.sv
dma_sequencer.sv
int_status.sv
sdmac_top.sv
sdmac_properties.sv
tb_sdmac.sv

//--- sdmac_addr_pkg.sv
// SDMAC address map, byte offsets of the registers and ports and the select enum
package sdmac_addr_pkg;

  // Internal register offsets, byte addresses inside the window
  localparam logic [6:0] off_dawr    = 7'h00;  // DACK width register
  localparam logic [6:0] off_wtc     = 7'h04;  // Word transfer count
  localparam logic [6:0] off_cntr    = 7'h08;  // Control register
  localparam logic [6:0] off_st_dma  = 7'h10;  // Start DMA strobe
  localparam logic [6:0] off_flush   = 7'h14;  // Flush strobe
  localparam logic [6:0] off_clr_int = 7'h18;  // Clear interrupts strobe
  localparam logic [6:0] off_istr    = 7'h1C;  // Interrupt status register
  localparam logic [6:0] off_sp_dma  = 7'h3C;  // Stop DMA strobe

  // External port groups, each covers 16 bytes
  localparam logic [6:0] off_port0   = 7'h40;  // SCSI controller
  localparam logic [6:0] off_port1a  = 7'h50;  // Port 1A
  localparam logic [6:0] off_port2   = 7'h60;  // Port 2
  localparam logic [6:0] off_port1b  = 7'h70;  // Port 1B, shares select with 1A

  // Decoded target of the current address
  typedef enum logic [3:0] {
    dawr,     // Width register
    wtc,      // Count register
    cntr,     // Control register
    st_dma,   // Start action
    flush,    // Flush action
    clr_int,  // Clear interrupt action
    istr,     // Status register
    sp_dma,   // Stop action
    port0,    // SCSI port
    port1,    // Ports 1A and 1B
    port2,    // Port 2
    none      // Unmapped offset
  } reg_sel_e;

endpackage

//--- sdmac_ctrl_pkg.sv
// SDMAC control and status bit layout and the DMA sequencer state type
package sdmac_ctrl_pkg;

  // Control register
  localparam int cntr_width = 9;   // Implemented control bits
  localparam int cntr_ddir  = 1;   // Direction, 1 means toward memory
  localparam int cntr_inten = 2;   // Interrupt output enable

  // Interrupt status register
  localparam int istr_width  = 9;  // Implemented status bits
  localparam int istr_ff_flg = 0;  // Flush done latch
  localparam int istr_tc     = 1;  // Terminal count latch
  localparam int istr_e_int  = 2;  // External interrupt level
  localparam int istr_scsi   = 3;  // SCSI interrupt level
  localparam int istr_int_p  = 4;  // Any source pending

  // DMA sequencer state
  typedef enum logic {
    dma_idle,    // No transfer, requests ignored
    dma_active   // Counting words on each request
  } dma_state_e;

endpackage

//--- sdmac_properties.sv
// SDMAC bound checks on address selects and DMA acknowledge
module sdmac_properties (
  input logic                      cpuclk,  // CPU clock
  input logic                      rst_n,   // Sync reset
  input logic                      cs_n,    // Chip select
  input logic                      as_n,    // Address strobe
  input logic [10:0]               sel_n,   // Register and port selects
  input sdmac_ctrl_pkg::dma_state_e state,  // Sequencer state
  input logic                      dack_n   // DMA acknowledge
);
  timeunit 1ns;
  timeprecision 1ps;
  import sdmac_ctrl_pkg::*;

  // Decoder never picks two targets at once
  sel_onehot: assert property (@(posedge cpuclk) $onehot0(~sel_n))
    else $error("more than one select low at the same time");

  // No access, no select
  sel_idle: assert property (@(posedge cpuclk) (cs_n || as_n) |-> (&sel_n))
    else $error("select low while chip select or address strobe is high");

  // Ack trails a request taken while active, so the state one edge back must be active
  dack_active: assert property (
    @(posedge cpuclk) disable iff (!rst_n)
    !dack_n |-> ($past(state) == dma_active)
  ) else $error("DMA acknowledge low without an active transfer");

endmodule

//--- sdmac_regs.sv
// SDMAC register file, access-start detection, writable registers, action pulses, read mux
module sdmac_regs #(
  parameter int wtc_width = 24                              // Word count width
) (
  input  logic                                 cpuclk,      // CPU clock
  input  logic                                 rst_n,       // Sync reset
  input  logic                                 rw,          // 1 read, 0 write
  input  logic [31:0]                          data_in,     // Write data
  input  logic                                 dawr_n,      // Width register select
  input  logic                                 wtc_n,       // Count register select
  input  logic                                 cntr_n,      // Control register select
  input  logic                                 st_dma_n,    // Start DMA select
  input  logic                                 flush_n,     // Flush select
  input  logic                                 clr_int_n,   // Clear interrupts select
  input  logic                                 istr_n,      // Status register select
  input  logic                                 sp_dma_n,    // Stop DMA select
  input  logic [wtc_width-1:0]                 wtc_rem,     // Live remaining count
  input  logic [sdmac_ctrl_pkg::istr_width-1:0] istr_word,  // Status word
  output logic [31:0]                          data_out,    // Read data
  output logic [wtc_width-1:0]                 wtc_load,    // Count to load on start
  output logic                                 inten,       // Interrupt enable
  output logic                                 ddir,        // DMA direction
  output logic                                 start_p,     // Start DMA pulse
  output logic                                 flush_p,     // Flush pulse
  output logic                                 stop_p,      // Stop DMA pulse
  output logic                                 clr_int_p    // Clear interrupts pulse
);
  import sdmac_ctrl_pkg::*;

  // Bit positions in the select vector
  localparam int idx_dawr    = 7;
  localparam int idx_wtc     = 6;
  localparam int idx_cntr    = 5;
  localparam int idx_st_dma  = 4;
  localparam int idx_flush   = 3;
  localparam int idx_clr_int = 2;
  localparam int idx_istr    = 1;
  localparam int idx_sp_dma  = 0;

  logic [7:0]            sel;        // Active-high selects
  logic [7:0]            sel_q;      // Selects at the previous edge
  logic [7:0]            sel_start;  // First cycle of each access
  logic [1:0]            dawr_q;     // DACK width
  logic [wtc_width-1:0]  wtc_q;      // Programmed word count
  logic [cntr_width-1:0] cntr_q;     // Control bits

  assign sel = ~{dawr_n, wtc_n, cntr_n, st_dma_n, flush_n, clr_int_n, istr_n, sp_dma_n};
  assign sel_start = sel & ~sel_q;   // Held strobe gives one start only

  always_ff @(posedge cpuclk) begin
    if (!rst_n) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel;
    end
  end

  // Writes land on the access-start edge only
  always_ff @(posedge cpuclk) begin
    if (!rst_n) begin
      dawr_q <= '0;
      wtc_q  <= '0;
      cntr_q <= '0;
    end else if (!rw) begin
      if (sel_start[idx_dawr]) dawr_q <= data_in[1:0];
      if (sel_start[idx_wtc])  wtc_q  <= data_in[wtc_width-1:0];
      if (sel_start[idx_cntr]) cntr_q <= data_in[cntr_width-1:0];
    end
  end

  // Action strobes fire on read or write alike
  always_ff @(posedge cpuclk) begin
    if (!rst_n) begin
      start_p   <= 1'b0;
      flush_p   <= 1'b0;
      stop_p    <= 1'b0;
      clr_int_p <= 1'b0;
    end else begin
      start_p   <= sel_start[idx_st_dma];
      flush_p   <= sel_start[idx_flush];
      stop_p    <= sel_start[idx_sp_dma];
      clr_int_p <= sel_start[idx_clr_int];
    end
  end

  // Read data, zero when no readable register is selected
  always_comb begin
    data_out = '0;
    if (sel[idx_dawr]) begin
      data_out[1:0] = dawr_q;
    end else if (sel[idx_wtc]) begin
      data_out[wtc_width-1:0] = wtc_rem;          // Count as it runs down
    end else if (sel[idx_cntr]) begin
      data_out[cntr_width-1:0] = cntr_q;
    end else if (sel[idx_istr]) begin
      data_out[istr_width-1:0] = istr_word;
    end
  end

  assign wtc_load = wtc_q;
  assign inten    = cntr_q[cntr_inten];
  assign ddir     = cntr_q[cntr_ddir];

endmodule

//--- sdmac_top.sv
// SDMAC register and control block top, joins decoder, registers, sequencer and interrupts
module sdmac_top #(
  parameter int wtc_width = 24        // Word count width, passed down
) (
  input  logic        cpuclk,         // CPU clock
  input  logic        rst_n,          // Sync reset
  input  logic [6:2]  addr,           // CPU longword address
  input  logic        cs_n,           // Chip select
  input  logic        as_n,           // Address strobe
  input  logic        rw,             // 1 read, 0 write
  input  logic [31:0] data_in,        // Write data
  output logic [31:0] data_out,       // Read data
  output logic        css_n,          // SCSI port select
  output logic        csx0_n,         // Port 1A and 1B select
  output logic        csx1_n,         // Port 2 select
  input  logic        dreq,           // DMA request
  output logic        dack_n,         // DMA acknowledge
  output logic        dma_active,     // Transfer running
  output logic        dma_dir,        // Direction from control register
  input  logic        scsi_int,       // SCSI interrupt level
  input  logic        ext_int,        // External interrupt level
  output logic        int2_n          // Interrupt to host
);
  import sdmac_ctrl_pkg::*;

  logic                  dawr_n, wtc_n, cntr_n, st_dma_n;    // Register selects
  logic                  flush_n, clr_int_n, istr_n, sp_dma_n;
  logic                  start_p, flush_p, stop_p, clr_int_p;  // Action pulses
  logic                  tc_p, flush_done_p;                  // Sequencer events
  logic                  inten;                               // Interrupt enable
  logic [wtc_width-1:0]  wtc_load;                            // Programmed count
  logic [wtc_width-1:0]  wtc_rem;                             // Live count
  logic [istr_width-1:0] istr_word;                           // Status word

  addr_decoder addr_decoder_inst (
    .addr(addr), .cs_n(cs_n), .as_n(as_n),
    .dawr_n(dawr_n), .wtc_n(wtc_n), .cntr_n(cntr_n), .st_dma_n(st_dma_n),
    .flush_n(flush_n), .clr_int_n(clr_int_n), .istr_n(istr_n), .sp_dma_n(sp_dma_n),
    .css_n(css_n), .csx0_n(csx0_n), .csx1_n(csx1_n)
  );

  sdmac_regs #(.wtc_width(wtc_width)) sdmac_regs_inst (
    .cpuclk(cpuclk), .rst_n(rst_n), .rw(rw), .data_in(data_in),
    .dawr_n(dawr_n), .wtc_n(wtc_n), .cntr_n(cntr_n), .st_dma_n(st_dma_n),
    .flush_n(flush_n), .clr_int_n(clr_int_n), .istr_n(istr_n), .sp_dma_n(sp_dma_n),
    .wtc_rem(wtc_rem), .istr_word(istr_word), .data_out(data_out),
    .wtc_load(wtc_load), .inten(inten), .ddir(dma_dir),     // Direction goes out as is
    .start_p(start_p), .flush_p(flush_p), .stop_p(stop_p), .clr_int_p(clr_int_p)
  );

  dma_sequencer #(.wtc_width(wtc_width)) dma_sequencer_inst (
    .cpuclk(cpuclk), .rst_n(rst_n),
    .start_p(start_p), .stop_p(stop_p), .flush_p(flush_p),
    .dreq(dreq), .wtc_load(wtc_load), .wtc_rem(wtc_rem),
    .tc_p(tc_p), .flush_done_p(flush_done_p),
    .dack_n(dack_n), .dma_active(dma_active)
  );

  int_status int_status_inst (
    .cpuclk(cpuclk), .rst_n(rst_n),
    .tc_p(tc_p), .flush_done_p(flush_done_p), .clr_int_p(clr_int_p),
    .scsi_int(scsi_int), .ext_int(ext_int), .inten(inten),
    .istr_word(istr_word), .int2_n(int2_n)
  );

endmodule

//--- tb_sdmac.sv
// SDMAC testbench driving xorshift bus stimulus checked every cycle against a reference model
module tb_sdmac;
  timeunit 1ns;
  timeprecision 1ps;
  import sdmac_addr_pkg::*;
  import sdmac_ctrl_pkg::*;

  localparam int wtc_width    = 24;
  localparam int n_rand       = 400;  // Fully random bus cycles
  localparam int n_regs       = 30;   // Write and readback rounds
  localparam int n_dma        = 8;    // Full transfers
  localparam int n_abort      = 8;    // Stopped or flushed transfers
  localparam int n_irq        = 12;   // Interrupt rounds
  localparam int test_cycles  = 4 + n_rand + n_regs * 12 + n_dma * 120 + n_abort * 30
                                + n_irq * 30 + 20;
  localparam int cycle_limit  = 2 * test_cycles;

  logic        cpuclk, rst_n, cs_n, as_n, rw, dreq, scsi_int, ext_int;
  logic [6:2]  addr;
  logic [31:0] data_in, data_out;
  logic        css_n, csx0_n, csx1_n, dack_n, dma_active, dma_dir, int2_n;

  logic [31:0] rng;                 // Xorshift state
  logic        dreq_en;             // Random requests allowed
  int          cycles = 0;          // Timeout counter

  logic [1:0]            m_dawr;    // Model registers
  logic [wtc_width-1:0]  m_wtc, m_count;
  logic [cntr_width-1:0] m_cntr;
  logic m_act, m_dack_n, m_tc_p, m_ff_p, m_tc, m_ff;
  logic m_start_p, m_flush_p, m_stop_p, m_clr_p, acc_start;
  reg_sel_e m_prev, tgt_edge, tgt_now;
  logic [istr_width-1:0] exp_istr;
  logic [31:0] exp_data;
  logic [7:0]  exp_sel;
  logic [6:0]  exp_pins;
  logic        pend;

  sdmac_top #(.wtc_width(wtc_width)) sdmac_top_inst (
    .cpuclk(cpuclk), .rst_n(rst_n), .addr(addr), .cs_n(cs_n), .as_n(as_n), .rw(rw),
    .data_in(data_in), .data_out(data_out), .css_n(css_n), .csx0_n(csx0_n),
    .csx1_n(csx1_n), .dreq(dreq), .dack_n(dack_n), .dma_active(dma_active),
    .dma_dir(dma_dir), .scsi_int(scsi_int), .ext_int(ext_int), .int2_n(int2_n)
  );

  bind sdmac_top sdmac_properties sdmac_properties_inst (
    .cpuclk(cpuclk), .rst_n(rst_n), .cs_n(cs_n), .as_n(as_n),
    .sel_n({dawr_n, wtc_n, cntr_n, st_dma_n, flush_n, clr_int_n, istr_n, sp_dma_n,
            css_n, csx0_n, csx1_n}),
    .state(dma_sequencer_inst.state), .dack_n(dack_n)
  );

  always #2 cpuclk = ~cpuclk;  // 4 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Address map from the offset table with ports decoded per 16-byte group
  function automatic reg_sel_e decode_target(input logic [6:2] a, input logic cs, input logic st);
    logic [6:0] off;
    reg_sel_e   t;
    off = {a, 2'b00};
    case (off)
      off_dawr:    t = dawr;
      off_wtc:     t = wtc;
      off_cntr:    t = cntr;
      off_st_dma:  t = st_dma;
      off_flush:   t = flush;
      off_clr_int: t = clr_int;
      off_istr:    t = istr;
      off_sp_dma:  t = sp_dma;
      default: begin
        if ({off[6:4], 4'h0} == off_port0) t = port0;
        else if ({off[6:4], 4'h0} == off_port1a || {off[6:4], 4'h0} == off_port1b) t = port1;
        else if ({off[6:4], 4'h0} == off_port2) t = port2;
        else t = none;  // Holes below 0x40
      end
    endcase
    if (cs || st) t = none;  // Needs both strobes low
    return t;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // One clock with side inputs refreshed on the edge
  task automatic step();
    logic [31:0] r;
    @(posedge cpuclk);
    r = next_rand();
    dreq     <= dreq_en && r[0];
    scsi_int <= (r[7:5] == 3'd0) ? !scsi_int : scsi_int;   // Slow toggling levels
    ext_int  <= (r[10:8] == 3'd0) ? !ext_int : ext_int;
  endtask

  // Access held for hold cycles where later data must not land
  task automatic bus_access(input logic [6:0] off, input logic write, input logic [31:0] wdata,
                            input int hold);
    step();
    addr    <= off[6:2];
    rw      <= !write;
    data_in <= wdata;
    cs_n    <= 1'b0;
    as_n    <= 1'b0;
    for (int i = 1; i < hold; i++) begin
      step();
      data_in <= next_rand();
    end
    step();
    cs_n <= 1'b1;
    as_n <= 1'b1;
    rw   <= 1'b1;
  endtask

  always @(posedge cpuclk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_limit);
      $display("TEST FAILED");
      $fatal(1, "stopped by cycle limit");
    end
  end

  // Reference model updating latches first, then sequencer, then registers
  always @(posedge cpuclk) begin
    if (!rst_n) begin
      m_dawr    = '0;
      m_wtc     = '0;
      m_count   = '0;
      m_cntr    = '0;
      m_act     = 1'b0;
      m_dack_n  = 1'b1;
      m_tc_p    = 1'b0;
      m_ff_p    = 1'b0;
      m_tc      = 1'b0;
      m_ff      = 1'b0;
      m_start_p = 1'b0;
      m_flush_p = 1'b0;
      m_stop_p  = 1'b0;
      m_clr_p   = 1'b0;
      m_prev    = none;
    end else begin
      if (m_tc_p) m_tc = 1'b1;
      else if (m_clr_p) m_tc = 1'b0;
      if (m_ff_p) m_ff = 1'b1;
      else if (m_clr_p) m_ff = 1'b0;
      m_ff_p   = m_flush_p;  // Flush completes at once
      m_tc_p   = 1'b0;
      m_dack_n = 1'b1;
      if (m_stop_p || m_flush_p) begin
        m_act = 1'b0;
      end else if (m_start_p) begin
        m_count = m_wtc;
        if (m_wtc == '0) begin
          m_tc_p = 1'b1;  // Empty transfer ends immediately
          m_act  = 1'b0;
        end else begin
          m_act = 1'b1;
        end
      end else if (m_act && dreq) begin
        m_dack_n = 1'b0;
        if (m_count == wtc_width'(1)) begin
          m_tc_p = 1'b1;
          m_act  = 1'b0;
        end
        m_count = m_count - wtc_width'(1);
      end
      tgt_edge  = decode_target(addr, cs_n, as_n);
      acc_start = (tgt_edge != none) && (tgt_edge != m_prev);
      m_start_p = acc_start && (tgt_edge == st_dma);
      m_flush_p = acc_start && (tgt_edge == flush);
      m_stop_p  = acc_start && (tgt_edge == sp_dma);
      m_clr_p   = acc_start && (tgt_edge == clr_int);
      if (acc_start && !rw) begin
        case (tgt_edge)
          dawr:    m_dawr = data_in[1:0];
          wtc:     m_wtc  = data_in[wtc_width-1:0];
          cntr:    m_cntr = data_in[cntr_width-1:0];
          default: ;
        endcase
      end
      m_prev = tgt_edge;
    end
  end

  // Outputs settle by the falling edge
  always @(negedge cpuclk) begin
    if (rst_n) begin
      tgt_now  = decode_target(addr, cs_n, as_n);
      pend     = m_tc || m_ff || ext_int || scsi_int;
      exp_istr = '0;
      exp_istr[istr_ff_flg] = m_ff;
      exp_istr[istr_tc]     = m_tc;
      exp_istr[istr_e_int]  = ext_int;
      exp_istr[istr_scsi]   = scsi_int;
      exp_istr[istr_int_p]  = pend;
      exp_data = '0;
      case (tgt_now)
        dawr:    exp_data = {30'b0, m_dawr};
        wtc:     exp_data = 32'(m_count);  // Live count
        cntr:    exp_data = 32'(m_cntr);
        istr:    exp_data = 32'(exp_istr);
        default: ;
      endcase
      exp_sel  = ~{tgt_now == dawr, tgt_now == wtc, tgt_now == cntr, tgt_now == st_dma,
                   tgt_now == flush, tgt_now == clr_int, tgt_now == istr, tgt_now == sp_dma};
      exp_pins = {tgt_now != port0, tgt_now != port1, tgt_now != port2, m_dack_n, m_act,
                  m_cntr[cntr_ddir], !(pend && m_cntr[cntr_inten])};
      check("register selects", 32'({sdmac_top_inst.dawr_n, sdmac_top_inst.wtc_n,
            sdmac_top_inst.cntr_n, sdmac_top_inst.st_dma_n, sdmac_top_inst.flush_n,
            sdmac_top_inst.clr_int_n, sdmac_top_inst.istr_n, sdmac_top_inst.sp_dma_n}),
            32'(exp_sel));
      check("pins css,csx0,csx1,dack,active,dir,int2",
            32'({css_n, csx0_n, csx1_n, dack_n, dma_active, dma_dir, int2_n}), 32'(exp_pins));
      check("data_out", data_out, exp_data);
    end
  end

  initial begin
    logic [31:0] r;
    logic [6:0]  off;
    cpuclk   = 1'b0;
    rst_n    = 1'b0;
    addr     = '0;
    cs_n     = 1'b1;
    as_n     = 1'b1;
    rw       = 1'b1;
    data_in  = '0;
    dreq     = 1'b0;
    scsi_int = 1'b0;
    ext_int  = 1'b0;
    dreq_en  = 1'b0;
    rng = 32'h55e7;
    repeat (4) @(posedge cpuclk);
    rst_n <= 1'b1;
    dreq_en = 1'b1;
    repeat (n_rand) begin  // Random decode sweep with every bus pin random
      step();
      r = next_rand();
      addr    <= r[4:0];
      cs_n    <= r[5];
      as_n    <= r[6];
      rw      <= r[7];
      data_in <= next_rand();
    end
    step();
    cs_n <= 1'b1;
    as_n <= 1'b1;
    bus_access(off_sp_dma, 1'b0, '0, 1);
    dreq_en = 1'b0;  // Count holds still for readback
    repeat (n_regs) begin
      r   = next_rand();
      off = (r[1:0] == 2'd0) ? off_dawr : (r[1:0] == 2'd1) ? off_wtc : off_cntr;
      bus_access(off, 1'b1, next_rand(), 1 + int'(r[3:2]));
      if (off == off_wtc) bus_access(off_st_dma, r[5], '0, 1);  // Loads count for readback
      bus_access(off, 1'b0, '0, 1 + int'(r[4]));
    end
    bus_access(off_sp_dma, 1'b1, '0, 1);
    dreq_en = 1'b1;
    repeat (n_dma) begin
      r = next_rand();
      bus_access(off_wtc, 1'b1, {28'b0, r[3:0]} + 32'd1, 1);
      bus_access(off_st_dma, r[5], '0, 1);
      step();
      do begin  // Until terminal count drops active
        r = next_rand();
        if (r[0]) bus_access(off_wtc, 1'b0, '0, 1 + int'(r[1]));
        else step();
        @(negedge cpuclk);
      end while (dma_active);
      bus_access(off_istr, 1'b0, '0, 1);
    end
    repeat (n_abort) begin
      r = next_rand();
      bus_access(off_wtc, 1'b1, 32'd20 + {27'b0, r[4:0]}, 1);
      bus_access(off_st_dma, 1'b0, '0, 1);
      repeat (2 + int'(r[7:6])) step();
      bus_access(r[8] ? off_flush : off_sp_dma, r[9], '0, 1);
      step();
      bus_access(off_istr, 1'b0, '0, 1);
    end
    repeat (n_irq) begin
      r = next_rand();
      bus_access(off_cntr, 1'b1, r, 1);  // Random inten and direction
      if (r[11]) begin
        bus_access(off_wtc, 1'b1, '0, 1);
        bus_access(off_st_dma, 1'b0, '0, 1);  // Zero count gives tc at once
      end
      bus_access(off_istr, 1'b0, '0, 1);
      bus_access(off_clr_int, r[12], '0, 1 + int'(r[13]));
      step();
      bus_access(off_istr, 1'b0, '0, 1);
    end
    repeat (4) step();
    $display("TEST PASSED");
    $finish;
  end

endmodule
